// File: Makefile
# Verilator flow for the line doubler

VERILATOR  ?= verilator
TOP        ?= tb_linemult
RTL_TOP    ?= linemult_top
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the run prints the pass line
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// File: line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module line_buffer #(
  parameter int LINE_PIXELS = 640,
  parameter int BUF_PAGES   = 4
) (
  input  wire      VCLK_o,
  buf_wr_if.buffer wr,
  buf_rd_if.buffer rd
);
  import video_pkg::*;

  localparam int DEPTH = BUF_PAGES * LINE_PIXELS;
  localparam int IDX_W = $clog2(DEPTH);

  color_in_t        mem [DEPTH];
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  // pages laid out back to back
  assign wr_idx = IDX_W'(wr.page * LINE_PIXELS + wr.addr);
  assign rd_idx = IDX_W'(rd.page * LINE_PIXELS + rd.addr);

  always_ff @(posedge VCLK_o) begin
    if (wr.wren)
      mem[wr_idx] <= wr.data;
    if (rd.rden)
      rd.data <= mem[rd_idx];  // registered read
  end

  // both page counters wrap at BUF_PAGES
  a_page_range: assert property (@(posedge VCLK_o)
    (wr.wren |-> wr.page < BUF_PAGES) and (rd.rden |-> rd.page < BUF_PAGES));

endmodule

`default_nettype wire

// File: line_reader.sv
`timescale 1ns/1ns
`default_nettype none

module line_reader #(
  parameter int LINE_PIXELS  = 640,
  parameter int OUT_LINE_LEN = 1600,
  parameter int OUT_HSTART   = 200,
  parameter int HS_WIDTH     = 64,
  parameter int BUF_PAGES    = 4
) (
  input  wire              VCLK_o,
  input  wire              nVRST_o,
  input  wire              enable_i,
  line_credit_if.reader    cr,
  buf_rd_if.reader         rd,
  output video_pkg::sync_t sync_o,
  output logic             de_o,
  output logic             shade_o
);
  import linemult_pkg::*;

  localparam int PAGE_W = (BUF_PAGES > 1) ? $clog2(BUF_PAGES) : 1;
  localparam int ADDR_W = (LINE_PIXELS > 1) ? $clog2(LINE_PIXELS) : 1;
  localparam int POS_W  = $clog2(OUT_LINE_LEN + 1);
  localparam int CNT_W  = $clog2(BUF_PAGES + 1);

  rd_state_t         state;
  logic [POS_W-1:0]  pos;  // position within the current copy
  logic              pos_last;
  logic              active;
  logic              pop;
  logic              nhs;
  logic              nvs;
  logic [PAGE_W-1:0] cur_page;
  logic              cur_vs;

  // queue of committed lines, {vsync, page}
  logic [PAGE_W:0]   fifo_mem [BUF_PAGES];
  logic [PAGE_W-1:0] fifo_wp;
  logic [PAGE_W-1:0] fifo_rp;
  logic [CNT_W-1:0]  fifo_cnt;

  function automatic logic [PAGE_W-1:0] ptr_inc(logic [PAGE_W-1:0] p);
    return (p == PAGE_W'(BUF_PAGES - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pos_last = (pos == POS_W'(OUT_LINE_LEN - 1));
  assign active   = (state != ST_WAIT_LINE);
  assign pop      = enable_i && (fifo_cnt != '0) &&
                    ((state == ST_WAIT_LINE) || (state == ST_SECOND_COPY && pos_last));

  ////////////////////
  // raster outputs, combinational from position

  assign nhs = !(active && pos < POS_W'(HS_WIDTH));
  assign nvs = !(active && cur_vs);  // whole copy for vsync lines

  always_comb begin
    sync_o        = '0;
    sync_o.nvsync = nvs;
    sync_o.nhsync = nhs;
    sync_o.ncsync = nhs && nvs;
  end

  assign de_o    = active && (pos >= POS_W'(OUT_HSTART)) &&
                   (pos < POS_W'(OUT_HSTART + LINE_PIXELS));
  assign shade_o = (state == ST_SECOND_COPY);

  assign rd.rden = de_o;
  assign rd.page = cur_page;
  assign rd.addr = ADDR_W'(pos - POS_W'(OUT_HSTART));

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      state         <= ST_WAIT_LINE;
      pos           <= '0;
      cur_page      <= '0;
      cur_vs        <= 1'b0;
      fifo_wp       <= '0;
      fifo_rp       <= '0;
      fifo_cnt      <= '0;
      cr.credit_ret <= 1'b0;
    end else begin
      cr.credit_ret <= 1'b0;
      case (state)
        ST_WAIT_LINE: begin
          pos <= '0;
        end
        ST_FIRST_COPY: begin
          pos <= pos + 1'b1;
          if (pos_last) begin
            state <= ST_SECOND_COPY;
            pos   <= '0;
          end
        end
        ST_SECOND_COPY: begin
          pos <= pos + 1'b1;
          if (pos_last) begin
            state         <= ST_WAIT_LINE;
            cr.credit_ret <= 1'b1;  // page done, back to the writer
          end
        end
        default: state <= ST_WAIT_LINE;
      endcase

      if (pop) begin  // next line follows without gap
        state    <= ST_FIRST_COPY;
        pos      <= '0;
        cur_page <= fifo_mem[fifo_rp][PAGE_W-1:0];
        cur_vs   <= fifo_mem[fifo_rp][PAGE_W];
        fifo_rp  <= ptr_inc(fifo_rp);
      end
      if (cr.line_valid)
        fifo_wp <= ptr_inc(fifo_wp);
      fifo_cnt <= fifo_cnt + CNT_W'(cr.line_valid) - CNT_W'(pop);

      if (!enable_i) begin
        state         <= ST_WAIT_LINE;
        pos           <= '0;
        fifo_wp       <= '0;
        fifo_rp       <= '0;
        fifo_cnt      <= '0;
        cr.credit_ret <= 1'b0;
      end
    end
  end

  always_ff @(posedge VCLK_o) begin
    if (cr.line_valid)
      fifo_mem[fifo_wp] <= {cr.line_vsync, cr.line_page};
  end

  // writer only commits with a credit, so a free slot must exist
  a_fifo_no_overflow: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    cr.line_valid |-> fifo_cnt < CNT_W'(BUF_PAGES));

endmodule

`default_nettype wire

// File: line_writer.sv
`timescale 1ns/1ns
`default_nettype none

module line_writer #(
  parameter int LINE_PIXELS = 640,
  parameter int IN_HSTART   = 128,
  parameter int BUF_PAGES   = 4
) (
  input  wire                       VCLK_o,
  input  wire                       nVRST_o,
  input  wire                       vdata_valid_i,
  input  wire video_pkg::vdata_in_t vdata_i,
  input  wire                       enable_i,
  buf_wr_if.writer                  wr,
  line_credit_if.writer             cr,
  output logic                      line_drop_o
);
  import linemult_pkg::*;

  localparam int PAGE_W   = (BUF_PAGES > 1) ? $clog2(BUF_PAGES) : 1;
  localparam int ADDR_W   = (LINE_PIXELS > 1) ? $clog2(LINE_PIXELS) : 1;
  localparam int CNT_W    = $clog2(IN_HSTART + LINE_PIXELS + 1);
  localparam int CRED_W   = $clog2(BUF_PAGES + 1);
  localparam int LAST_IDX = IN_HSTART + LINE_PIXELS - 1;

  wr_state_t         state;
  logic              nhs_last;  // nHSYNC of previous valid pixel
  logic [CNT_W-1:0]  pix_cnt;   // index of next valid pixel
  logic [CNT_W-1:0]  pix_idx;
  logic [CRED_W-1:0] credits;
  logic [CRED_W-1:0] cred_nxt;
  logic [PAGE_W-1:0] wr_page;
  logic              vs_flag;
  logic              last_wr;   // last window pixel goes to the buffer
  logic              line_start;
  logic              has_credit;
  logic              capt;
  logic              in_win;

  assign line_start = vdata_valid_i && nhs_last && !vdata_i.sync.nhsync;
  assign has_credit = credits > CRED_W'(last_wr);  // commit in flight not yet debited
  assign pix_idx    = line_start ? '0 : pix_cnt;
  assign in_win     = (pix_idx >= CNT_W'(IN_HSTART)) && (pix_idx <= CNT_W'(LAST_IDX));
  assign capt       = line_start ? (enable_i && has_credit) : (state == ST_CAPTURE);

  assign wr.page = wr_page;

  always_comb begin
    cred_nxt = credits;
    if (cr.credit_ret && credits != CRED_W'(BUF_PAGES))
      cred_nxt = cred_nxt + 1'b1;
    if (last_wr)
      cred_nxt = cred_nxt - 1'b1;  // committed line holds its page
  end

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      state         <= ST_WAIT_HS;
      nhs_last      <= 1'b0;
      pix_cnt       <= '0;
      credits       <= CRED_W'(BUF_PAGES);
      wr_page       <= '0;
      last_wr       <= 1'b0;
      wr.wren       <= 1'b0;
      cr.line_valid <= 1'b0;
      line_drop_o   <= 1'b0;
    end else begin
      wr.wren       <= 1'b0;
      last_wr       <= 1'b0;
      cr.line_valid <= last_wr;
      line_drop_o   <= 1'b0;
      credits       <= cred_nxt;
      if (last_wr)
        wr_page <= (wr_page == PAGE_W'(BUF_PAGES - 1)) ? '0 : wr_page + 1'b1;

      if (vdata_valid_i) begin
        nhs_last <= vdata_i.sync.nhsync;
        if (capt && in_win)
          wr.wren <= 1'b1;
        if (line_start) begin
          pix_cnt <= CNT_W'(1);
          if (!enable_i) begin
            state <= ST_WAIT_HS;
          end else if (has_credit) begin
            state <= ST_CAPTURE;
          end else begin
            state       <= ST_DROP;
            line_drop_o <= 1'b1;
          end
        end else if (state == ST_CAPTURE) begin
          pix_cnt <= pix_cnt + 1'b1;
          if (pix_idx == CNT_W'(LAST_IDX)) begin
            state   <= ST_WAIT_HS;
            last_wr <= 1'b1;
          end
        end
      end

      if (!enable_i) begin  // bypass mode, all pages free again
        state         <= ST_WAIT_HS;
        credits       <= CRED_W'(BUF_PAGES);
        wr_page       <= '0;
        wr.wren       <= 1'b0;
        last_wr       <= 1'b0;
        cr.line_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge VCLK_o) begin
    if (vdata_valid_i && capt && in_win) begin
      wr.addr <= ADDR_W'(pix_idx - CNT_W'(IN_HSTART));
      wr.data <= vdata_i.color;
    end
    if (line_start)
      vs_flag <= !vdata_i.sync.nvsync;
    if (last_wr) begin
      cr.line_page  <= wr_page;
      cr.line_vsync <= vs_flag;
    end
  end

  ////////////////////
  // credit bookkeeping against the reader

  a_commit_has_credit: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    cr.line_valid |-> $past(credits) != '0);

  a_credit_bound: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    cr.credit_ret && !last_wr |-> credits < CRED_W'(BUF_PAGES));

endmodule

`default_nettype wire

// File: linemult_ifs.sv
`timescale 1ns/1ns
`default_nettype none

interface buf_wr_if #(
  parameter int PAGE_W = 2,
  parameter int ADDR_W = 10
);
  import video_pkg::*;

  logic              wren;
  logic [PAGE_W-1:0] page;
  logic [ADDR_W-1:0] addr;
  color_in_t         data;

  modport writer (output wren, page, addr, data);
  modport buffer (input wren, page, addr, data);
endinterface

interface buf_rd_if #(
  parameter int PAGE_W = 2,
  parameter int ADDR_W = 10
);
  import video_pkg::*;

  logic              rden;
  logic [PAGE_W-1:0] page;
  logic [ADDR_W-1:0] addr;
  color_in_t         data;  // one cycle after rden

  modport reader (output rden, page, addr);
  modport buffer (input rden, page, addr, output data);
  modport sink   (input data);
endinterface

interface line_credit_if #(
  parameter int PAGE_W = 2
);
  logic              line_valid;  // line committed, one cycle
  logic [PAGE_W-1:0] line_page;
  logic              line_vsync;
  logic              credit_ret;  // page released, one cycle

  modport writer (output line_valid, line_page, line_vsync, input credit_ret);
  modport reader (input line_valid, line_page, line_vsync, output credit_ret);
endinterface

`default_nettype wire

// File: linemult_pkg.sv
`default_nettype none

package linemult_pkg;

  typedef enum logic [1:0] {
    ST_WAIT_HS,  // between lines
    ST_CAPTURE,
    ST_DROP      // no free page for this line
  } wr_state_t;

  typedef enum logic [1:0] {
    ST_WAIT_LINE,
    ST_FIRST_COPY,
    ST_SECOND_COPY
  } rd_state_t;

  ////////////////////
  // default line timing

  localparam int DEF_LINE_PIXELS  = 640;
  localparam int DEF_IN_HSTART    = 128;
  localparam int DEF_OUT_LINE_LEN = 1600;  // two output lines per input line
  localparam int DEF_OUT_HSTART   = 200;
  localparam int DEF_HS_WIDTH     = 64;
  localparam int DEF_BUF_PAGES    = 4;

endpackage

`default_nettype wire

// File: linemult_top.sv
`timescale 1ns/1ns
`default_nettype none

module linemult_top #(
  parameter int LINE_PIXELS  = linemult_pkg::DEF_LINE_PIXELS,
  parameter int IN_HSTART    = linemult_pkg::DEF_IN_HSTART,
  parameter int OUT_LINE_LEN = linemult_pkg::DEF_OUT_LINE_LEN,
  parameter int OUT_HSTART   = linemult_pkg::DEF_OUT_HSTART,
  parameter int HS_WIDTH     = linemult_pkg::DEF_HS_WIDTH,
  parameter int BUF_PAGES    = linemult_pkg::DEF_BUF_PAGES
) (
  input  wire                        VCLK_o,
  input  wire                        nVRST_o,
  input  wire                        vdata_valid_i,
  input  wire video_pkg::vdata_in_t  vdata_i,
  input  wire                        lx2_en_i,
  input  wire                        sl_en_i,
  input  wire [7:0]                  sl_str_i,
  output wire                        vdata_valid_o,
  output wire video_pkg::vdata_out_t vdata_o,
  output wire                        de_o,
  output wire                        line_drop_o
);
  import video_pkg::*;

  localparam int PAGE_W = (BUF_PAGES > 1) ? $clog2(BUF_PAGES) : 1;
  localparam int ADDR_W = (LINE_PIXELS > 1) ? $clog2(LINE_PIXELS) : 1;

  sync_t rd_sync;   // raster from the reader
  logic  rd_de;
  logic  rd_shade;

  buf_wr_if #(.PAGE_W(PAGE_W), .ADDR_W(ADDR_W)) buf_wr ();
  buf_rd_if #(.PAGE_W(PAGE_W), .ADDR_W(ADDR_W)) buf_rd ();
  line_credit_if #(.PAGE_W(PAGE_W)) credit ();

  line_writer #(
    .LINE_PIXELS (LINE_PIXELS),
    .IN_HSTART   (IN_HSTART),
    .BUF_PAGES   (BUF_PAGES)
  ) line_writer_i (
    .VCLK_o        (VCLK_o),
    .nVRST_o       (nVRST_o),
    .vdata_valid_i (vdata_valid_i),
    .vdata_i       (vdata_i),
    .enable_i      (lx2_en_i),
    .wr            (buf_wr.writer),
    .cr            (credit.writer),
    .line_drop_o   (line_drop_o)
  );

  line_buffer #(
    .LINE_PIXELS (LINE_PIXELS),
    .BUF_PAGES   (BUF_PAGES)
  ) line_buffer_i (
    .VCLK_o (VCLK_o),
    .wr     (buf_wr.buffer),
    .rd     (buf_rd.buffer)
  );

  line_reader #(
    .LINE_PIXELS  (LINE_PIXELS),
    .OUT_LINE_LEN (OUT_LINE_LEN),
    .OUT_HSTART   (OUT_HSTART),
    .HS_WIDTH     (HS_WIDTH),
    .BUF_PAGES    (BUF_PAGES)
  ) line_reader_i (
    .VCLK_o   (VCLK_o),
    .nVRST_o  (nVRST_o),
    .enable_i (lx2_en_i),
    .cr       (credit.reader),
    .rd       (buf_rd.reader),
    .sync_o   (rd_sync),
    .de_o     (rd_de),
    .shade_o  (rd_shade)
  );

  scanline_shader scanline_shader_i (
    .VCLK_o        (VCLK_o),
    .nVRST_o       (nVRST_o),
    .lx2_en_i      (lx2_en_i),
    .sl_en_i       (sl_en_i),
    .sl_str_i      (sl_str_i),
    .sync_i        (rd_sync),
    .de_i          (rd_de),
    .shade_i       (rd_shade),
    .rd            (buf_rd.sink),
    .vdata_valid_i (vdata_valid_i),
    .vdata_i       (vdata_i),
    .vdata_valid_o (vdata_valid_o),
    .vdata_o       (vdata_o),
    .de_o          (de_o)
  );

endmodule

`default_nettype wire

// File: scanline_shader.sv
`timescale 1ns/1ns
`default_nettype none

module scanline_shader (
  input  wire                       VCLK_o,
  input  wire                       nVRST_o,
  input  wire                       lx2_en_i,
  input  wire                       sl_en_i,
  input  wire [7:0]                 sl_str_i,
  input  wire video_pkg::sync_t     sync_i,
  input  wire                       de_i,
  input  wire                       shade_i,
  buf_rd_if.sink                    rd,
  input  wire                       vdata_valid_i,
  input  wire video_pkg::vdata_in_t vdata_i,
  output logic                      vdata_valid_o,
  output video_pkg::vdata_out_t     vdata_o,
  output logic                      de_o
);
  import video_pkg::*;

  sync_t      sync_d;   // aligned with buffer data
  logic       de_d;
  logic       shade_d;
  sync_t      sync_m;   // multiply stage
  logic       de_m;
  color_out_t col_exp;
  color_out_t col_dim;
  color_out_t col_m;

  // floor(c * s / 256)
  function automatic logic [COLOR_W_OUT-1:0] dim(logic [COLOR_W_OUT-1:0] c,
                                                 logic [7:0] s);
    logic [COLOR_W_OUT+7:0] p;
    p = c * s;
    return p[COLOR_W_OUT+7:8];
  endfunction

  assign col_exp = expand_color(rd.data);

  always_comb begin
    col_dim.r = dim(col_exp.r, sl_str_i);
    col_dim.g = dim(col_exp.g, sl_str_i);
    col_dim.b = dim(col_exp.b, sl_str_i);
  end

  always_ff @(posedge VCLK_o) begin
    if (!de_d)
      col_m <= '0;  // blanking
    else if (shade_d)
      col_m <= col_dim;
    else
      col_m <= col_exp;
  end

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      sync_d        <= SYNC_IDLE;
      de_d          <= 1'b0;
      shade_d       <= 1'b0;
      sync_m        <= SYNC_IDLE;
      de_m          <= 1'b0;
      vdata_valid_o <= 1'b0;
      vdata_o       <= '{sync: SYNC_IDLE, color: '0};
      de_o          <= 1'b0;
    end else begin
      sync_d  <= sync_i;
      de_d    <= de_i;
      shade_d <= shade_i && sl_en_i;  // second copy only
      sync_m  <= sync_d;
      de_m    <= de_d;

      if (lx2_en_i) begin
        vdata_valid_o <= 1'b1;  // timed raster, every cycle
        vdata_o       <= '{sync: sync_m, color: col_m};
        de_o          <= de_m;
      end else begin  // bypass
        vdata_valid_o <= vdata_valid_i;
        vdata_o       <= '{sync: vdata_i.sync, color: expand_color(vdata_i.color)};
        de_o          <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb.f
video_pkg.sv
linemult_pkg.sv
linemult_ifs.sv
line_writer.sv
line_buffer.sv
line_reader.sv
scanline_shader.sv
linemult_top.sv
tb_linemult.sv

// File: tb_linemult.sv
`timescale 1ns/1ns
`default_nettype none

module tb_linemult;
  import video_pkg::*;

  localparam int LINE_PIXELS  = 16;
  localparam int IN_HSTART    = 4;
  localparam int OUT_LINE_LEN = 40;
  localparam int OUT_HSTART   = 10;
  localparam int HS_WIDTH     = 4;
  localparam int BUF_PAGES    = 4;

  localparam int CLK_NS      = 8;
  localparam int IN_LINE_LEN = 48;  // valid pixels per input line
  localparam int IN_HS_LEN   = 4;   // input hsync low pixels
  localparam int TOTAL_LINES = 31;  // 3 + 6 + 6 + 4 + 12
  localparam int MARGIN_NS   = 30000;
  localparam int WATCHDOG_NS = TOTAL_LINES * 2 * OUT_LINE_LEN * CLK_NS + MARGIN_NS;

  logic       VCLK_o;
  logic       nVRST_o;
  logic       vdata_valid_in;
  vdata_in_t  vdata_in;
  logic       lx2_en;
  logic       sl_en;
  logic [7:0] sl_str;
  logic       vdata_valid_out;
  vdata_out_t vdata_out;
  logic       de_out;
  logic       line_drop;

  integer    seed = 32'habc2_e549;
  color_in_t model_pix[$];  // window pixels, LINE_PIXELS per line, oldest first
  logic      model_vs[$];   // vsync flag per line
  int        checks;
  int        errors;
  int        out_lines;
  int        drops;
  logic      mon_on;

  // inputs as the DUT saw them at the last rising edge
  logic       valid_q;
  vdata_in_t  data_q;
  logic       lx2_q;
  logic       sl_en_q;
  logic [7:0] sl_str_q;

  // output raster tracking
  logic prev_nhs;
  logic in_copy;
  int   rpos;       // position inside the current copy
  logic cur_copy;   // 1 on the second copy
  logic next_copy;
  logic cur_vs;

  linemult_top #(
    .LINE_PIXELS  (LINE_PIXELS),
    .IN_HSTART    (IN_HSTART),
    .OUT_LINE_LEN (OUT_LINE_LEN),
    .OUT_HSTART   (OUT_HSTART),
    .HS_WIDTH     (HS_WIDTH),
    .BUF_PAGES    (BUF_PAGES)
  ) linemult_top_i (
    .VCLK_o        (VCLK_o),
    .nVRST_o       (nVRST_o),
    .vdata_valid_i (vdata_valid_in),
    .vdata_i       (vdata_in),
    .lx2_en_i      (lx2_en),
    .sl_en_i       (sl_en),
    .sl_str_i      (sl_str),
    .vdata_valid_o (vdata_valid_out),
    .vdata_o       (vdata_out),
    .de_o          (de_out),
    .line_drop_o   (line_drop)
  );

  initial begin
    VCLK_o = 1'b0;
    forever #(CLK_NS / 2) VCLK_o = ~VCLK_o;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the DUT stopped delivering lines", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////
  // expected pixel

  function automatic color_out_t ref_pixel(color_in_t c, logic second, logic sl_on,
                                           logic [7:0] str);
    color_out_t e;
    e.r = {c.r, c.r[COLOR_W_IN-1]};  // top bit reused as lsb
    e.g = {c.g, c.g[COLOR_W_IN-1]};
    e.b = {c.b, c.b[COLOR_W_IN-1]};
    if (second && sl_on) begin
      e.r = 8'((int'(e.r) * int'(str)) / 256);
      e.g = 8'((int'(e.g) * int'(str)) / 256);
      e.b = 8'((int'(e.b) * int'(str)) / 256);
    end
    return e;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s mismatch, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // stimulus

  task automatic drive(input logic valid, input sync_t s, input color_in_t c);
    @(negedge VCLK_o);
    vdata_valid_in = valid;
    vdata_in       = {s, c};
  endtask

  task automatic idle_pixels(input int n);
    sync_t s;
    s = 4'b1011;  // all syncs high
    for (int i = 0; i < n; i++) begin
      drive(1'b1, s, '0);
      drive(1'b0, s, '0);
    end
  endtask

  task automatic send_line(input logic vs, input logic fast, input logic record);
    color_in_t   px[$];
    sync_t       s;
    logic [31:0] r;
    for (int i = 0; i < IN_LINE_LEN; i++) begin
      r = $random(seed);
      px.push_back(r[20:0]);
    end
    if (record) begin
      for (int i = 0; i < LINE_PIXELS; i++)
        model_pix.push_back(px[IN_HSTART + i]);
      model_vs.push_back(vs);
    end
    for (int i = 0; i < IN_LINE_LEN; i++) begin
      s.nvsync = !vs;
      s.rsvd   = 1'b0;
      s.nhsync = (i >= IN_HS_LEN);
      s.ncsync = s.nvsync && s.nhsync;
      drive(1'b1, s, px[i]);
      if (!fast)
        drive(1'b0, s, px[i]);  // valid every second cycle
    end
  endtask

  task automatic wait_drain();
    while (model_vs.size() != 0)
      @(negedge VCLK_o);
    idle_pixels(2);
  endtask

  task automatic report_test(input string name, input int chk0, input int err0);
    $display("test %s finished: %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  ////////////////////
  // output checking

  task automatic check_raster();
    sync_t s;
    int    px;
    logic  de_exp;
    s = vdata_out.sync;
    if (prev_nhs && !s.nhsync) begin  // hsync falls, a copy starts
      if (model_vs.size() == 0) begin
        errors++;
        $display("an output copy started at %0t ns with no line left in the model", $time);
      end else begin
        in_copy   = 1'b1;
        rpos      = 0;
        cur_copy  = next_copy;
        next_copy = !next_copy;
        cur_vs    = model_vs[0];
      end
    end else if (in_copy) begin
      rpos++;
    end
    check_equal(32'(vdata_valid_out), 32'd1, "raster valid");
    check_equal(32'(s.ncsync), 32'(s.nhsync && s.nvsync), "csync");
    if (in_copy) begin
      de_exp = (rpos >= OUT_HSTART) && (rpos < OUT_HSTART + LINE_PIXELS);
      check_equal(32'(s.nhsync), 32'(rpos >= HS_WIDTH), "hsync");
      check_equal(32'(s.nvsync), 32'(!cur_vs), "vsync");
      check_equal(32'(de_out), 32'(de_exp), "de");
      if (de_exp) begin
        px = rpos - OUT_HSTART;
        check_equal(32'(vdata_out.color),
                    32'(ref_pixel(model_pix[px], cur_copy, sl_en_q, sl_str_q)), "pixel");
      end else begin
        check_equal(32'(vdata_out.color), 32'd0, "blank colour");
      end
      if (rpos == OUT_LINE_LEN - 1) begin
        in_copy = 1'b0;
        if (cur_copy) begin  // both copies out, line done
          for (int i = 0; i < LINE_PIXELS; i++)
            void'(model_pix.pop_front());
          void'(model_vs.pop_front());
          out_lines++;
        end
      end
    end else begin
      check_equal(32'(de_out), 32'd0, "idle de");
      check_equal(32'(s.nvsync), 32'd1, "idle vsync");
    end
  endtask

  always @(posedge VCLK_o) begin
    valid_q  <= vdata_valid_in;
    data_q   <= vdata_in;
    lx2_q    <= lx2_en;
    sl_en_q  <= sl_en;
    sl_str_q <= sl_str;
  end

  // outputs are registered, so the falling edge sees them settled
  always @(negedge VCLK_o) begin
    if (mon_on) begin
      if (!lx2_q) begin
        check_equal(32'(vdata_valid_out), 32'(valid_q), "bypass valid");
        check_equal(32'(vdata_out),
                    32'({data_q.sync, ref_pixel(data_q.color, 1'b0, 1'b0, 8'd0)}),
                    "bypass pixel");
        check_equal(32'(de_out), 32'd0, "bypass de");
      end else begin
        check_raster();
      end
      if (line_drop) begin  // newest line had no page
        drops++;
        if (model_vs.size() == 0) begin
          errors++;
          $display("a line drop at %0t ns found no line in the model", $time);
        end else begin
          for (int i = 0; i < LINE_PIXELS; i++)
            void'(model_pix.pop_back());
          void'(model_vs.pop_back());
        end
      end
    end
    prev_nhs = vdata_out.sync.nhsync;
  end

  ////////////////////
  // test sequence

  initial begin
    int          chk0;
    int          err0;
    int          out0;
    int          drop0;
    logic [31:0] r;
    nVRST_o        = 1'b0;
    vdata_valid_in = 1'b0;
    vdata_in       = {4'b1011, 21'd0};
    lx2_en         = 1'b0;
    sl_en          = 1'b0;
    sl_str         = 8'd0;
    checks         = 0;
    errors         = 0;
    out_lines      = 0;
    drops          = 0;
    mon_on         = 1'b0;
    prev_nhs       = 1'b1;
    in_copy        = 1'b0;
    rpos           = 0;
    cur_copy       = 1'b0;
    next_copy      = 1'b0;
    cur_vs         = 1'b0;
    repeat (5) @(posedge VCLK_o);
    @(negedge VCLK_o);
    nVRST_o = 1'b1;
    repeat (2) @(negedge VCLK_o);
    mon_on = 1'b1;

    chk0 = checks;
    err0 = errors;
    idle_pixels(2);
    send_line(1'b0, 1'b0, 1'b0);
    send_line(1'b1, 1'b0, 1'b0);
    send_line(1'b0, 1'b0, 1'b0);
    report_test("bypass", chk0, err0);

    chk0   = checks;
    err0   = errors;
    out0   = out_lines;
    lx2_en = 1'b1;
    idle_pixels(2);
    repeat (6) send_line(1'b0, 1'b0, 1'b1);
    wait_drain();
    check_equal(out_lines - out0, 6, "doubled line count");
    report_test("doubling", chk0, err0);

    chk0   = checks;
    err0   = errors;
    out0   = out_lines;
    r      = $random(seed);
    sl_en  = 1'b1;
    sl_str = r[7:0];
    repeat (6) send_line(1'b0, 1'b0, 1'b1);
    wait_drain();
    check_equal(out_lines - out0, 6, "scanline line count");
    report_test("scanlines", chk0, err0);

    chk0  = checks;
    err0  = errors;
    out0  = out_lines;
    sl_en = 1'b0;
    send_line(1'b1, 1'b0, 1'b1);
    send_line(1'b1, 1'b0, 1'b1);
    send_line(1'b0, 1'b0, 1'b1);
    send_line(1'b0, 1'b0, 1'b1);
    wait_drain();
    check_equal(out_lines - out0, 4, "vsync line count");
    report_test("raster and vsync", chk0, err0);

    // input every cycle outruns the double playback
    chk0   = checks;
    err0   = errors;
    out0   = out_lines;
    drop0  = drops;
    r      = $random(seed);
    sl_en  = 1'b1;
    sl_str = r[7:0];
    repeat (12) send_line(1'b0, 1'b1, 1'b1);
    wait_drain();
    check_equal((out_lines - out0) + (drops - drop0), 12, "lines out plus drops");
    check_equal(32'((drops - drop0) > 0), 32'd1, "overflow drops seen");
    report_test("overflow", chk0, err0);

    $display("summary: %0d checks, %0d errors, %0d lines out, %0d lines dropped",
             checks, errors, out_lines, drops);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: video_pkg.sv
`default_nettype none

package video_pkg;

  localparam int COLOR_W_IN  = 7;  // per channel, from the console
  localparam int COLOR_W_OUT = 8;  // per channel, towards the DAC

  typedef struct packed {
    logic [COLOR_W_IN-1:0] r;
    logic [COLOR_W_IN-1:0] g;
    logic [COLOR_W_IN-1:0] b;
  } color_in_t;

  typedef struct packed {
    logic [COLOR_W_OUT-1:0] r;
    logic [COLOR_W_OUT-1:0] g;
    logic [COLOR_W_OUT-1:0] b;
  } color_out_t;

  // sync nibble as on the video bus
  typedef struct packed {
    logic nvsync;
    logic rsvd;    // always zero
    logic nhsync;
    logic ncsync;
  } sync_t;

  typedef struct packed {
    sync_t     sync;
    color_in_t color;
  } vdata_in_t;

  typedef struct packed {
    sync_t      sync;
    color_out_t color;
  } vdata_out_t;

  localparam sync_t SYNC_IDLE = '{nvsync: 1'b1, rsvd: 1'b0, nhsync: 1'b1, ncsync: 1'b1};

  // msb repeated as the new lsb
  function automatic color_out_t expand_color(color_in_t c);
    color_out_t e;
    e.r = {c.r, c.r[COLOR_W_IN-1]};
    e.g = {c.g, c.g[COLOR_W_IN-1]};
    e.b = {c.b, c.b[COLOR_W_IN-1]};
    return e;
  endfunction

endpackage

`default_nettype wire
